// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path and word address width
`define CPU_DATA_W 32

// general registers r0 to r7
`define CPU_NREGS 8
`define CPU_REG_W 3

// instruction field widths
`define CPU_OP_W 7
`define CPU_IMM_W 16

`endif

// File: cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] word_t;
    typedef logic [`CPU_DATA_W-1:0] addr_t;
    typedef logic [`CPU_REG_W-1:0]  reg_idx_t;
    typedef logic [`CPU_IMM_W-1:0]  imm_t;

    // opcodes sit in bits 6 to 0 of the instruction word
    typedef enum logic [`CPU_OP_W-1:0] {
        OP_NOP = 7'd0,
        OP_ADD = 7'd1,
        OP_SUB = 7'd2,
        OP_AND = 7'd3,
        OP_OR  = 7'd4,
        OP_XOR = 7'd5,
        OP_LDI = 7'd6,
        OP_ST  = 7'd7,
        OP_LD  = 7'd8,
        OP_BZ  = 7'd9,
        OP_JMP = 7'd10
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_PASS_B,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // one instruction per pass through the three states
    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        WRITEBACK
    } cpu_state_t;

endpackage

// File: cpu_decode.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_decode (
    input  cpu_pkg::word_t    instr,
    output cpu_pkg::reg_idx_t ra,
    output cpu_pkg::reg_idx_t rb,
    output cpu_pkg::reg_idx_t rd,
    output cpu_pkg::imm_t     imm,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              use_imm,
    output logic              reg_write,
    output logic              flag_write,
    output logic              mem_read,
    output logic              mem_write,
    output logic              branch,
    output logic              jump
);
    import cpu_pkg::*;

    opcode_t opcode;

    // fixed field positions
    assign opcode = opcode_t'(instr[`CPU_OP_W-1:0]);
    assign ra     = instr[9:7];
    assign rb     = instr[12:10];
    assign rd     = instr[15:13];
    assign imm    = instr[`CPU_DATA_W-1 -: `CPU_IMM_W];

    always_comb begin
        alu_op     = ALU_PASS_B;
        use_imm    = 1'b0;
        reg_write  = 1'b0;
        flag_write = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                reg_write  = 1'b1;
                flag_write = 1'b1;
                case (opcode)
                    OP_ADD:  alu_op = ALU_ADD;
                    OP_SUB:  alu_op = ALU_SUB;
                    OP_AND:  alu_op = ALU_AND;
                    OP_OR:   alu_op = ALU_OR;
                    default: alu_op = ALU_XOR;
                endcase
            end
            OP_LDI: begin
                // imm passes straight through the alu
                use_imm    = 1'b1;
                reg_write  = 1'b1;
                flag_write = 1'b1;
            end
            OP_ST: begin
                mem_write = 1'b1;
            end
            OP_LD: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OP_BZ: begin
                branch = 1'b1;
            end
            OP_JMP: begin
                jump = 1'b1;
            end
            // nop and unknown opcodes keep every control low
            default: begin
            end
        endcase
    end

endmodule

// File: cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
    input  logic             clock,
    input  cpu_pkg::alu_op_t alu_op,
    input  cpu_pkg::word_t   operand_a,
    input  cpu_pkg::word_t   operand_b,
    input  cpu_pkg::imm_t    imm,
    input  logic             use_imm,
    output cpu_pkg::word_t   alu_result,
    output logic             alu_zero
);
    import cpu_pkg::*;

    word_t second_op;
    word_t result;

    // immediate is zero-extended
    assign second_op = use_imm ? word_t'(imm) : operand_b;

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = operand_a + second_op;
            end
            ALU_SUB: begin
                result = operand_a - second_op;
            end
            ALU_AND: begin
                result = operand_a & second_op;
            end
            ALU_OR: begin
                result = operand_a | second_op;
            end
            ALU_XOR: begin
                result = operand_a ^ second_op;
            end
            default: begin
                result = second_op;
            end
        endcase
    end

    // execute stage register
    // inputs do not change between execute and writeback, so the value holds
    always_ff @(posedge clock) begin
        alu_result <= result;
        alu_zero   <= (result == '0);
    end

endmodule

// File: cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_regfile (
    input  logic              clock,
    input  logic              rst,
    input  cpu_pkg::reg_idx_t ra,
    input  cpu_pkg::reg_idx_t rb,
    input  cpu_pkg::reg_idx_t rd,
    input  logic              wb_en,
    input  logic              reg_write,
    input  logic              flag_write,
    input  logic              mem_read,
    input  cpu_pkg::word_t    alu_result,
    input  logic              alu_zero,
    input  cpu_pkg::word_t    load_data,
    output cpu_pkg::word_t    rd_a,
    output cpu_pkg::word_t    rd_b,
    output logic              flag_a
);
    import cpu_pkg::*;

    word_t                 regs [`CPU_NREGS];
    logic [`CPU_NREGS-1:0] flags;
    word_t                 wb_data;

    // result stage select picks the memory word for ld
    assign wb_data = mem_read ? load_data : alu_result;

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
        end else if (wb_en) begin
            if (reg_write) begin
                regs[rd] <= wb_data;
            end
            if (flag_write) begin
                flags[rd] <= alu_zero;
            end
        end
    end

    // asynchronous read ports
    assign rd_a   = regs[ra];
    assign rd_b   = regs[rb];
    assign flag_a = flags[ra];

endmodule

// File: cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input  logic           clock,
    input  logic           rst,
    input  cpu_pkg::word_t data,
    input  logic           mem_write,
    input  logic           branch,
    input  logic           jump,
    input  logic           mem_read,
    input  logic           flag_a,
    input  cpu_pkg::imm_t  imm,
    input  cpu_pkg::word_t rd_a,
    input  cpu_pkg::word_t rd_b,
    output cpu_pkg::word_t instr,
    output logic           wb_en,
    output cpu_pkg::addr_t address,
    output cpu_pkg::word_t datao,
    output logic           rw
);
    import cpu_pkg::*;

    cpu_state_t state;
    addr_t      pc;
    addr_t      pc_next;
    logic       take_target;
    logic       mem_access;

    // jmp always, bz only when the flag of ra is set
    assign take_target = jump | (branch & flag_a);
    assign pc_next     = take_target ? addr_t'(imm) : pc + addr_t'(1);
    assign mem_access  = mem_read | mem_write;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= FETCH;
            pc    <= '0;
            instr <= '0;
        end else begin
            case (state)
                FETCH: begin
                    instr <= data;
                    state <= EXECUTE;
                end
                EXECUTE: begin
                    state <= WRITEBACK;
                end
                WRITEBACK: begin
                    pc    <= pc_next;
                    state <= FETCH;
                end
                default: begin
                    state <= FETCH;
                end
            endcase
        end
    end

    assign wb_en = (state == WRITEBACK);

    // writes only in writeback of st
    assign rw = wb_en & mem_write;

    // data address from rb for ld and st, else the instruction address
    assign address = (wb_en & mem_access) ? addr_t'(rd_b) : pc;

    assign datao = rw ? rd_a : '0;

endmodule

// File: cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic           clock,
    input  logic           rst,
    input  cpu_pkg::word_t data,
    output cpu_pkg::word_t datao,
    output cpu_pkg::addr_t address,
    output logic           rw
);
    import cpu_pkg::*;

    word_t    instr;
    reg_idx_t ra;
    reg_idx_t rb;
    reg_idx_t rd;
    imm_t     imm;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     reg_write;
    logic     flag_write;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     jump;
    word_t    rd_a;
    word_t    rd_b;
    logic     flag_a;
    word_t    alu_result;
    logic     alu_zero;
    logic     wb_en;

    cpu_decode u_decode (
        .instr      (instr),
        .ra         (ra),
        .rb         (rb),
        .rd         (rd),
        .imm        (imm),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .reg_write  (reg_write),
        .flag_write (flag_write),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .branch     (branch),
        .jump       (jump)
    );

    cpu_alu u_alu (
        .clock      (clock),
        .alu_op     (alu_op),
        .operand_a  (rd_a),
        .operand_b  (rd_b),
        .imm        (imm),
        .use_imm    (use_imm),
        .alu_result (alu_result),
        .alu_zero   (alu_zero)
    );

    // load data comes straight from the bus
    cpu_regfile u_regfile (
        .clock      (clock),
        .rst        (rst),
        .ra         (ra),
        .rb         (rb),
        .rd         (rd),
        .wb_en      (wb_en),
        .reg_write  (reg_write),
        .flag_write (flag_write),
        .mem_read   (mem_read),
        .alu_result (alu_result),
        .alu_zero   (alu_zero),
        .load_data  (data),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .flag_a     (flag_a)
    );

    cpu_control u_control (
        .clock     (clock),
        .rst       (rst),
        .data      (data),
        .mem_write (mem_write),
        .branch    (branch),
        .jump      (jump),
        .mem_read  (mem_read),
        .flag_a    (flag_a),
        .imm       (imm),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .instr     (instr),
        .wb_en     (wb_en),
        .address   (address),
        .datao     (datao),
        .rw        (rw)
    );

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    // about 260 cycles of tests in total, so this leaves a wide margin
    localparam int CYCLE_LIMIT = 2000;

    logic  clock = 1'b0;
    logic  rst = 1'b1;
    word_t data;
    word_t datao;
    addr_t address;
    logic  rw;

    word_t mem [256] = '{default: '0};
    word_t image [256];
    logic  load_image = 1'b0;
    int    prog_len = 0;
    addr_t log_addr [$];
    word_t log_data [$];
    word_t lcg_state = 32'h9a59_a034;
    int    errors = 0;
    int    cycles = 0;

    cpu u_cpu (
        .clock   (clock),
        .rst     (rst),
        .data    (data),
        .datao   (datao),
        .address (address),
        .rw      (rw)
    );

    always #50 clock = ~clock;

    // memory answers in the same cycle
    assign data = mem[address[7:0]];

    always @(posedge clock) begin
        if (load_image) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= image[i];
            end
        end else if (rw) begin
            mem[address[7:0]] <= datao;
            log_addr.push_back(address);
            log_data.push_back(datao);
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no end of run after %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // low seven bits stay zero so a stray fetch decodes as nop
    function automatic word_t fill_word(input int i);
        return 32'hf000_0000 | (word_t'(i) << 7);
    endfunction

    function automatic word_t encode_instr(input opcode_t op, input reg_idx_t rd,
                                           input reg_idx_t ra, input reg_idx_t rb,
                                           input imm_t imm);
        return {imm, rd, rb, ra, op};
    endfunction

    function automatic void clear_image();
        for (int i = 0; i < 256; i++) begin
            image[i] = fill_word(i);
        end
        prog_len = 0;
    endfunction

    function automatic void emit(input word_t w);
        image[prog_len] = w;
        prog_len++;
    endfunction

    // jump to itself
    function automatic void emit_halt();
        emit(encode_instr(OP_JMP, 3'd0, 3'd0, 3'd0, imm_t'(prog_len)));
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic expect_store_count(input int n);
        if (log_addr.size() != n) begin
            $display("expected %0d store cycles but saw %0d", n, log_addr.size());
            errors++;
        end
    endtask

    task automatic expect_store(input int idx, input addr_t exp_addr, input word_t exp_data);
        if (idx >= log_addr.size()) begin
            $display("store cycle %0d never happened", idx);
            errors++;
        end else begin
            check_addr($sformatf("store %0d address", idx), log_addr[idx], exp_addr);
            check_word($sformatf("store %0d datao", idx), log_data[idx], exp_data);
        end
    endtask

    // copy the image into memory and hold rst for 5 cycles
    task automatic load_and_reset();
        @(posedge clock);
        rst        <= 1'b1;
        load_image <= 1'b1;
        @(posedge clock);
        load_image <= 1'b0;
        repeat (4) begin
            @(negedge clock);
            if (rw !== 1'b0) begin
                $display("rw was not low while rst was high");
                errors++;
            end
            @(posedge clock);
        end
        log_addr.delete();
        log_data.delete();
        rst <= 1'b0;
    endtask

    task automatic run_instrs(input int n);
        repeat (3 * n) @(posedge clock);
        @(negedge clock);
    endtask

    task automatic alu_ops();
        imm_t    imm_a;
        imm_t    imm_b;
        word_t   a;
        word_t   b;
        word_t   expected [5];
        opcode_t ops [5];
        imm_a = imm_t'(next_rand() >> 16);
        imm_b = imm_t'(next_rand() >> 16);
        a = word_t'(imm_a);
        b = word_t'(imm_b);
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
        expected = '{a + b, a - b, a & b, a | b, a ^ b};
        clear_image();
        emit(encode_instr(OP_LDI, 3'd1, 3'd0, 3'd0, imm_a));
        emit(encode_instr(OP_LDI, 3'd2, 3'd0, 3'd0, imm_b));
        for (int k = 0; k < 5; k++) begin
            emit(encode_instr(OP_LDI, 3'd7, 3'd0, 3'd0, imm_t'(32'h80 + k)));
            emit(encode_instr(ops[k], 3'd3, 3'd1, 3'd2, 16'h0000));
            emit(encode_instr(OP_ST, 3'd0, 3'd3, 3'd7, 16'h0000));
        end
        emit_halt();
        load_and_reset();
        run_instrs(17);
        for (int k = 0; k < 5; k++) begin
            check_word($sformatf("mem[%0h]", 128 + k), mem[128 + k], expected[k]);
        end
    endtask

    task automatic load_store();
        word_t words [3];
        clear_image();
        for (int k = 0; k < 3; k++) begin
            words[k] = next_rand();
            image[144 + k] = words[k];
            emit(encode_instr(OP_LDI, 3'd1, 3'd0, 3'd0, imm_t'(32'h90 + k)));
            emit(encode_instr(OP_LD, 3'd2, 3'd0, 3'd1, 16'h0000));
            emit(encode_instr(OP_LDI, 3'd3, 3'd0, 3'd0, imm_t'(32'ha0 + k)));
            emit(encode_instr(OP_ST, 3'd0, 3'd2, 3'd3, 16'h0000));
        end
        emit_halt();
        load_and_reset();
        run_instrs(12);
        expect_store_count(3);
        for (int k = 0; k < 3; k++) begin
            expect_store(k, addr_t'(32'ha0 + k), words[k]);
        end
    endtask

    task automatic branch_on_flag();
        imm_t v;
        v = imm_t'((next_rand() >> 17) | 32'h1);
        clear_image();
        emit(encode_instr(OP_LDI, 3'd1, 3'd0, 3'd0, v));
        emit(encode_instr(OP_LDI, 3'd2, 3'd0, 3'd0, v));
        emit(encode_instr(OP_SUB, 3'd3, 3'd1, 3'd2, 16'h0000));
        emit(encode_instr(OP_LDI, 3'd7, 3'd0, 3'd0, 16'h00b0));
        emit(encode_instr(OP_LDI, 3'd4, 3'd0, 3'd0, 16'h00a1));
        emit(encode_instr(OP_BZ, 3'd0, 3'd3, 3'd0, 16'd7));
        emit(encode_instr(OP_ST, 3'd0, 3'd4, 3'd7, 16'h0000));
        // second half sees a nonzero difference
        emit(encode_instr(OP_LDI, 3'd2, 3'd0, 3'd0, v + 16'd1));
        emit(encode_instr(OP_SUB, 3'd5, 3'd1, 3'd2, 16'h0000));
        emit(encode_instr(OP_LDI, 3'd7, 3'd0, 3'd0, 16'h00b1));
        emit(encode_instr(OP_LDI, 3'd4, 3'd0, 3'd0, 16'h5a5a));
        emit(encode_instr(OP_BZ, 3'd0, 3'd5, 3'd0, 16'd13));
        emit(encode_instr(OP_ST, 3'd0, 3'd4, 3'd7, 16'h0000));
        emit_halt();
        load_and_reset();
        run_instrs(12);
        expect_store_count(1);
        expect_store(0, 32'h0000_00b1, 32'h0000_5a5a);
        check_word("mem[b0]", mem[176], fill_word(176));
    endtask

    task automatic jump_and_loop();
        int count;
        count = 2 + int'(next_rand() >> 30);
        clear_image();
        emit(encode_instr(OP_LDI, 3'd7, 3'd0, 3'd0, 16'h00c0));
        emit(encode_instr(OP_JMP, 3'd0, 3'd0, 3'd0, 16'd3));
        emit(encode_instr(OP_ST, 3'd0, 3'd7, 3'd7, 16'h0000));
        emit(encode_instr(OP_LDI, 3'd1, 3'd0, 3'd0, imm_t'(count)));
        emit(encode_instr(OP_LDI, 3'd2, 3'd0, 3'd0, 16'h0001));
        // loop body stores the counter at c0 plus counter
        emit(encode_instr(OP_ADD, 3'd6, 3'd1, 3'd7, 16'h0000));
        emit(encode_instr(OP_ST, 3'd0, 3'd1, 3'd6, 16'h0000));
        emit(encode_instr(OP_SUB, 3'd1, 3'd1, 3'd2, 16'h0000));
        emit(encode_instr(OP_BZ, 3'd0, 3'd1, 3'd0, 16'd10));
        emit(encode_instr(OP_JMP, 3'd0, 3'd0, 3'd0, 16'd5));
        emit_halt();
        load_and_reset();
        run_instrs(3 + 5 * count);
        expect_store_count(count);
        for (int k = 0; k < count; k++) begin
            expect_store(k, addr_t'(32'hc0 + count - k), word_t'(count - k));
        end
    endtask

    task automatic reset_and_unknown_op();
        clear_image();
        // the word at address 0 is a store, so rw would rise if reset let the FSM run
        // r7 is nonzero from the loop test and reads zero only after reset
        emit(encode_instr(OP_ST, 3'd0, 3'd7, 3'd7, 16'h0000));
        emit(encode_instr(OP_LDI, 3'd1, 3'd0, 3'd0, 16'h0077));
        emit(encode_instr(OP_LDI, 3'd2, 3'd0, 3'd0, 16'h00d0));
        // would overwrite r1 if it acted like ldi
        emit(encode_instr(opcode_t'(7'h7f), 3'd1, 3'd1, 3'd2, 16'hffff));
        emit(encode_instr(OP_ST, 3'd0, 3'd1, 3'd2, 16'h0000));
        emit_halt();
        load_and_reset();
        @(negedge clock);
        check_addr("address", address, 32'h0000_0000);
        run_instrs(5);
        expect_store_count(2);
        expect_store(0, 32'h0000_0000, 32'h0000_0000);
        expect_store(1, 32'h0000_00d0, 32'h0000_0077);
    endtask

    initial begin
        alu_ops();
        load_store();
        branch_on_flag();
        jump_and_loop();
        reset_and_unknown_op();
        $display("all tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
cpu_pkg.sv
cpu_decode.sv
cpu_alu.sv
cpu_regfile.sv
cpu_control.sv
cpu.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_cpu -o tb_cpu_sim

./obj_dir/tb_cpu_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "Test completed successfully" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
